// File: compile.f
source/fetch_pkg.sv
source/bus_pkg.sv
source/fetch_pc_unit.sv
source/icache_array.sv
source/refill_fsm.sv
source/bus_wait_timer.sv
source/fetch_top.sv
test/fetch_properties.sv
test/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module fetch_tb -o fetch_sim \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q 'All tests passed!' sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// File: source/bus_pkg.sv
// Instruction bus request and response types plus the acknowledge timeout
// Import where the Wishbone read side is driven, sampled or timed
`default_nettype none

package bus_pkg;

   import fetch_pkg::*;

   localparam int BUS_TIMEOUT_CYCLES = 16;   // Ack wait limit before fault

   typedef logic [4:0] timer_cnt_t;          // Holds 0..BUS_TIMEOUT_CYCLES

   // Read request, we and sel tied off at the pins
   typedef struct packed {
      logic cyc;
      logic stb;
      pc_t  adr;                             // Word address
   } bus_req_t;

   // Read response from the slave
   typedef struct packed {
      logic   ack;
      instr_t dat;
   } bus_rsp_t;

endpackage

`default_nettype wire

// File: source/bus_wait_timer.sv
// Counts cycles spent waiting for a bus acknowledge
// Flags a timeout once the wait reaches the limit from bus_pkg
`timescale 1ns/1ps
`default_nettype none

module bus_wait_timer import bus_pkg::*; (
   input  logic gclk,
   input  logic grst,
   input  logic wait_active_i,        // Request outstanding
   output logic timeout_o
);

   timer_cnt_t cnt_q;                 // Wait cycles so far
   logic       at_limit;

   assign at_limit = (cnt_q == timer_cnt_t'(BUS_TIMEOUT_CYCLES));

   always_ff @(posedge gclk) begin
      if (grst || !wait_active_i) begin
         cnt_q <= '0;                 // Restart for every request
      end else if (!at_limit) begin
         cnt_q <= cnt_q + timer_cnt_t'(1);
      end
   end

   // Saturates at the limit until the wait ends
   assign timeout_o = wait_active_i && at_limit;

endmodule

`default_nettype wire

// File: source/fetch_pc_unit.sv
// Program counter selection, delivered instruction strobe and PC pipeline
// Drives the cache lookup address and takes back hit and fault status
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit import fetch_pkg::*; (
   input  logic       gclk,
   input  logic       grst,
   input  logic       adv_i,          // Downstream takes an instruction
   input  redirect_t  bra_i,          // Branch strobe
   input  logic       hzd_i,          // Replay last delivered PC
   input  logic       hit_i,          // Lookup PC present in cache
   input  instr_t     hit_instr_i,
   input  logic       refill_busy_i,  // Miss pending or bus read running
   input  logic       exc_i,          // Bus fault pulse
   output pc_t        lookup_pc_o,
   output fetch_out_t fet_o,
   output pc_t        pc_ex_o,
   output pc_t        pc_mx_o
);

   pc_t       pc_q;                   // Current fetch address
   pc_t       pc_d;
   pc_t       pc_inc;
   redirect_t pend_q;                 // Branch waiting for refill to finish
   redirect_t pend_d;
   redirect_t bra_sel;                // Live strobe wins over pending one
   logic      br_apply;
   logic      br_stall;
   logic      replay;
   logic      deliver;
   logic      fet_valid_q;
   pc_t       fet_pc_q;
   instr_t    fet_instr_q;
   pc_t       pc_of_q;                // Decode stage PC
   pc_t       pc_ex_q;                // Execute stage PC
   pc_t       pc_mx_q;                // Memory stage PC

   assign pc_inc = pc_q + pc_t'(1);   // Next sequential word

   always_comb begin
      bra_sel  = bra_i.valid ? bra_i : pend_q;
      // Redirect only once the bus is quiet
      br_apply = bra_sel.valid && !refill_busy_i && !exc_i;
      br_stall = bra_sel.valid && refill_busy_i;
      // Hazard only counts right after a delivery, branch beats it
      replay   = hzd_i && fet_valid_q && !bra_sel.valid;
      // Hit in the branch cycle itself still goes out
      deliver  = hit_i && adv_i && !exc_i && !br_stall && !replay;
   end

   // Next PC priority
   always_comb begin
      pc_d = pc_q;                    // Hold by default
      if (exc_i) begin
         pc_d = EXC_VECTOR_PC;
      end else if (br_apply) begin
         pc_d = bra_sel.target;
      end else if (replay) begin
         pc_d = fet_pc_q;             // Same word again
      end else if (deliver) begin
         pc_d = pc_inc;
      end
   end

   // Pending redirect bookkeeping
   always_comb begin
      pend_d = pend_q;
      if (exc_i || br_apply) begin
         pend_d = '0;                 // Consumed or flushed by fault
      end else if (bra_i.valid) begin
         pend_d = bra_i;              // Park it until refill ends
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         pc_q        <= RESET_PC;
         pend_q      <= '0;
         fet_valid_q <= 1'b0;
      end else begin
         pc_q        <= pc_d;
         pend_q      <= pend_d;
         fet_valid_q <= deliver;      // One cycle strobe
      end
   end

   // Delivered word and its address
   always_ff @(posedge gclk) begin
      if (deliver) begin
         fet_pc_q    <= pc_q;
         fet_instr_q <= hit_instr_i;
      end
   end

   // Stage PCs move one step per delivery
   always_ff @(posedge gclk) begin
      if (grst) begin
         pc_of_q <= '0;
         pc_ex_q <= '0;
         pc_mx_q <= '0;
      end else if (fet_valid_q) begin
         pc_mx_q <= pc_ex_q;
         pc_ex_q <= pc_of_q;
         pc_of_q <= fet_pc_q;
      end
   end

   assign lookup_pc_o = pc_q;
   assign fet_o       = '{valid: fet_valid_q, pc: fet_pc_q, instr: fet_instr_q};
   assign pc_ex_o     = pc_ex_q;
   assign pc_mx_o     = pc_mx_q;

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
// Fetch side types and sizes shared by the PC unit, I-cache and refill logic
// Import into any module that handles PCs, instructions or redirects
`default_nettype none

package fetch_pkg;

   localparam int PC_BITS           = 30;                          // Word address, bits 31:2
   localparam int ICACHE_INDEX_BITS = 4;                           // 16 lines
   localparam int ICACHE_LINES      = 1 << ICACHE_INDEX_BITS;
   localparam int ICACHE_TAG_BITS   = PC_BITS - ICACHE_INDEX_BITS; // 26 bits

   typedef logic [PC_BITS-1:0]           pc_t;
   typedef logic [31:0]                  instr_t;
   typedef logic [ICACHE_INDEX_BITS-1:0] icache_index_t;
   typedef logic [ICACHE_TAG_BITS-1:0]   icache_tag_t;

   localparam pc_t RESET_PC      = 30'h0000_0000;
   localparam pc_t EXC_VECTOR_PC = 30'h0000_0040;                // Fetch fault entry

   // Branch request, one cycle strobe
   typedef struct packed {
      logic valid;
      pc_t  target;
   } redirect_t;

   // Instruction handed to decode
   typedef struct packed {
      logic   valid;
      pc_t    pc;
      instr_t instr;
   } fetch_out_t;

   function automatic icache_index_t pc_index(input pc_t pc);
      return pc[ICACHE_INDEX_BITS-1:0];                          // Low bits pick the line
   endfunction

   function automatic icache_tag_t pc_tag(input pc_t pc);
      return pc[PC_BITS-1:ICACHE_INDEX_BITS];
   endfunction

endpackage

`default_nettype wire

// File: source/fetch_top.sv
// Instruction fetch subsystem top, PC unit plus I-cache and bus refill
// Connect ibus to a Wishbone read slave and fet_o to decode
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*, bus_pkg::*; (
   input  logic       gclk,
   input  logic       grst,
   input  logic       adv_i,          // Decode ready
   input  redirect_t  bra_i,          // Branch from execute
   input  logic       hzd_i,          // Replay request
   input  bus_rsp_t   ibus_rsp_i,
   output bus_req_t   ibus_req_o,
   output fetch_out_t fet_o,
   output pc_t        pc_ex_o,
   output pc_t        pc_mx_o,
   output logic       exc_iwb_o       // Fetch bus fault
);

   pc_t    lookup_pc;
   logic   hit;
   instr_t hit_instr;
   logic   fill_we;
   pc_t    fill_pc;
   instr_t fill_instr;
   logic   refill_busy;
   logic   wait_active;
   logic   timeout;

   fetch_pc_unit u_pc (
      .gclk          (gclk),
      .grst          (grst),
      .adv_i         (adv_i),
      .bra_i         (bra_i),
      .hzd_i         (hzd_i),
      .hit_i         (hit),
      .hit_instr_i   (hit_instr),
      .refill_busy_i (refill_busy),
      .exc_i         (exc_iwb_o),
      .lookup_pc_o   (lookup_pc),
      .fet_o         (fet_o),
      .pc_ex_o       (pc_ex_o),
      .pc_mx_o       (pc_mx_o)
   );

   icache_array u_icache (
      .gclk         (gclk),
      .grst         (grst),
      .lookup_pc_i  (lookup_pc),
      .fill_we_i    (fill_we),
      .fill_pc_i    (fill_pc),
      .fill_instr_i (fill_instr),
      .hit_o        (hit),
      .hit_instr_o  (hit_instr)
   );

   refill_fsm u_refill (
      .gclk          (gclk),
      .grst          (grst),
      .lookup_pc_i   (lookup_pc),
      .hit_i         (hit),
      .ibus_rsp_i    (ibus_rsp_i),
      .timeout_i     (timeout),
      .ibus_req_o    (ibus_req_o),
      .wait_active_o (wait_active),
      .fill_we_o     (fill_we),
      .fill_pc_o     (fill_pc),
      .fill_instr_o  (fill_instr),
      .busy_o        (refill_busy),
      .exc_o         (exc_iwb_o)
   );

   bus_wait_timer u_timer (
      .gclk          (gclk),
      .grst          (grst),
      .wait_active_i (wait_active),
      .timeout_o     (timeout)
   );

endmodule

`default_nettype wire

// File: source/icache_array.sv
// Direct mapped instruction cache storage, one word per line
// Lookup is combinational, refill writes land on the clock edge
`timescale 1ns/1ps
`default_nettype none

module icache_array import fetch_pkg::*; (
   input  logic   gclk,
   input  logic   grst,
   input  pc_t    lookup_pc_i,        // Address from PC unit
   input  logic   fill_we_i,          // Refill write strobe
   input  pc_t    fill_pc_i,          // Address being refilled
   input  instr_t fill_instr_i,       // Word from the bus
   output logic   hit_o,
   output instr_t hit_instr_o
);

   logic [ICACHE_LINES-1:0] valid_q;  // Line holds a real word
   icache_tag_t             tag_mem  [ICACHE_LINES];
   instr_t                  data_mem [ICACHE_LINES];

   icache_index_t rd_idx;
   icache_tag_t   rd_tag;
   icache_index_t wr_idx;
   icache_tag_t   wr_tag;

   assign rd_idx = pc_index(lookup_pc_i);
   assign rd_tag = pc_tag(lookup_pc_i);
   assign wr_idx = pc_index(fill_pc_i);
   assign wr_tag = pc_tag(fill_pc_i);

   // Valid bits, only state cleared at reset
   always_ff @(posedge gclk) begin
      if (grst) begin
         valid_q <= '0;
      end else if (fill_we_i) begin
         valid_q[wr_idx] <= 1'b1;
      end
   end

   // Tag and word storage
   always_ff @(posedge gclk) begin
      if (fill_we_i) begin
         tag_mem[wr_idx]  <= wr_tag;
         data_mem[wr_idx] <= fill_instr_i;
      end
   end

   // Hit check
   assign hit_o       = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
   assign hit_instr_o = data_mem[rd_idx];       // Meaningful only on hit

endmodule

`default_nettype wire

// File: source/refill_fsm.sv
// Cache miss handler, one Wishbone read per miss then a cache line write
// Drops the bus and raises a fault pulse when the wait timer expires
`timescale 1ns/1ps
`default_nettype none

module refill_fsm import fetch_pkg::*, bus_pkg::*; (
   input  logic     gclk,
   input  logic     grst,
   input  pc_t      lookup_pc_i,      // Address that missed
   input  logic     hit_i,
   input  bus_rsp_t ibus_rsp_i,
   input  logic     timeout_i,        // Ack never came
   output bus_req_t ibus_req_o,
   output logic     wait_active_o,    // Timer runs while high
   output logic     fill_we_o,
   output pc_t      fill_pc_o,
   output instr_t   fill_instr_o,
   output logic     busy_o,
   output logic     exc_o
);

   typedef enum logic [1:0] {
      IDLE,                           // Watching for a miss
      REQUEST,                        // cyc and stb up, waiting for ack
      FILL,                           // Write word into the cache
      FAULT                           // Report bus timeout
   } refill_state_t;

   refill_state_t state_q;
   refill_state_t state_d;
   pc_t           fill_pc_q;          // Captured miss address
   instr_t        fill_instr_q;       // Captured bus data

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (!hit_i) begin
               state_d = REQUEST;
            end
         end
         REQUEST: begin
            if (ibus_rsp_i.ack) begin
               state_d = FILL;        // Ack wins a tie with timeout
            end else if (timeout_i) begin
               state_d = FAULT;
            end
         end
         FILL:    state_d = IDLE;
         FAULT:   state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge gclk) begin
      if (state_q == IDLE && !hit_i) begin
         fill_pc_q <= lookup_pc_i;    // Address fixed for whole cycle
      end
      if (state_q == REQUEST && ibus_rsp_i.ack) begin
         fill_instr_q <= ibus_rsp_i.dat;
      end
   end

   // Bus outputs straight from state, drop the cycle after ack
   assign ibus_req_o    = '{cyc: (state_q == REQUEST), stb: (state_q == REQUEST),
                            adr: fill_pc_q};
   assign wait_active_o = (state_q == REQUEST);
   assign fill_we_o     = (state_q == FILL);
   assign fill_pc_o     = fill_pc_q;
   assign fill_instr_o  = fill_instr_q;
   assign busy_o        = (state_q != IDLE) || !hit_i;  // Miss counts as in flight
   assign exc_o         = (state_q == FAULT);           // Single cycle

endmodule

`default_nettype wire

// File: test/fetch_properties.sv
// Bus handshake and fault strobe assertions bound into every refill_fsm
// Watches the refill side of the instruction bus and the fault pulse width
`timescale 1ns/1ps
`default_nettype none

module fetch_properties import bus_pkg::*; (
   input logic     gclk,
   input logic     grst,
   input bus_req_t req_i,
   input bus_rsp_t rsp_i,
   input logic     exc_i
);

   // Cycle and strobe both fall the cycle after an ack
   drop_after_ack: assert property (@(posedge gclk) disable iff (grst)
      (req_i.cyc && rsp_i.ack) |=> (!req_i.cyc && !req_i.stb))
      else $error("ibus request still up after ack");

   // Address frozen while waiting unless a timeout drops the request
   adr_held: assert property (@(posedge gclk) disable iff (grst)
      (req_i.stb && !rsp_i.ack) |=> (!req_i.stb || $stable(req_i.adr)))
      else $error("ibus address moved before ack");

   exc_one_cycle: assert property (@(posedge gclk) disable iff (grst)
      exc_i |=> !exc_i)
      else $error("fetch fault pulse longer than one cycle");

endmodule

bind refill_fsm fetch_properties u_props (
   .gclk  (gclk),
   .grst  (grst),
   .req_i (ibus_req_o),
   .rsp_i (ibus_rsp_i),
   .exc_i (exc_o)
);

`default_nettype wire

// File: test/fetch_tb.sv
// Testbench for fetch_top with a Wishbone read slave and a reference PC model
// Runs as the top module fetch_tb on random stimulus from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*, bus_pkg::*; ();

   localparam int CLK_PERIOD    = 100;
   localparam int RANDOM_CYCLES = 2000;
   localparam int TEST_BUDGET   = 200 + 500 + 300 + 600 + 250 + RANDOM_CYCLES;
   localparam int WORST_REFILL  = BUS_TIMEOUT_CYCLES + 4;   // Timeout plus fill and restart
   localparam pc_t FAULT_PC     = pc_t'('h300);             // Slave never acks this word

   logic       gclk = 1'b0;
   logic       grst = 1'b1;
   logic       adv_i = 1'b0;
   logic       hzd_i = 1'b0;
   redirect_t  bra_i = '0;
   bus_rsp_t   ibus_rsp_i = '0;
   bus_req_t   ibus_req_o;
   fetch_out_t fet_o;
   pc_t        pc_ex_o;
   pc_t        pc_mx_o;
   logic       exc_iwb_o;

   pc_t  exp_pc;                       // Model of the next word to go out
   pc_t  br_tgt;
   logic br_pend = 1'b0;               // Branch seen but target not yet delivered
   pc_t  h1;                           // Last delivered PC
   pc_t  h2;                           // Two deliveries back
   pc_t  h3;                           // Three deliveries back
   pc_t  last_del_pc;
   pc_t  force_tgt;
   pc_t  win_lo = pc_t'('h200);        // Loop window for bus read counting
   logic fault_on = 1'b0;
   logic rand_adv = 1'b0;
   logic rand_br = 1'b0;
   logic rand_hzd = 1'b0;
   logic prev_cyc = 1'b0;
   logic slave_busy = 1'b0;
   int   slave_wait = 0;
   int   br_seq = 0;                   // Directed branch requests
   int   br_taken = 0;
   int   del_count = 0;
   int   exc_count = 0;
   int   replay_count = 0;
   int   win_reads = 0;
   int   checks = 0;
   int   errors = 0;

   fetch_top uut (
      .gclk       (gclk),
      .grst       (grst),
      .adv_i      (adv_i),
      .bra_i      (bra_i),
      .hzd_i      (hzd_i),
      .ibus_rsp_i (ibus_rsp_i),
      .ibus_req_o (ibus_req_o),
      .fet_o      (fet_o),
      .pc_ex_o    (pc_ex_o),
      .pc_mx_o    (pc_mx_o),
      .exc_iwb_o  (exc_iwb_o)
   );

   // Memory contents as a fixed scramble of the word address
   function automatic instr_t word_hash(input pc_t pc);
      return ({pc, 2'b00} * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
   endfunction

   function automatic pc_t pick_target();
      pc_t t;
      t = pc_t'($urandom_range(63));   // 64 word window
      // Keep clear of the sequential words that may still go out before the jump
      if (t == exp_pc || t == exp_pc + pc_t'(1)) begin
         t = t ^ pc_t'(8);
      end
      return t;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   initial begin
      forever #(CLK_PERIOD / 2) gclk = ~gclk;
   end

   initial begin
      #(TEST_BUDGET * WORST_REFILL * CLK_PERIOD);
      $display("Watchdog expired before the tests completed");
      $display("Test failures found");
      $finish;
   end

   // Stimulus changes right after the rising edge
   always @(posedge gclk) begin
      if (!grst) begin
         adv_i <= rand_adv ? ($urandom_range(99) < 80) : 1'b1;
         bra_i <= '0;
         hzd_i <= 1'b0;
         if (br_seq != br_taken) begin
            bra_i    <= '{valid: 1'b1, target: force_tgt};
            br_taken = br_seq;
         end else if (rand_br && !br_pend && $urandom_range(99) < 3) begin
            bra_i <= '{valid: 1'b1, target: pick_target()};
         end else if (rand_hzd && !br_pend && $urandom_range(99) < 15) begin
            hzd_i <= 1'b1;             // Only acts right after a delivery
         end
      end
   end

   // Wishbone slave acks after 1 to 6 cycles unless the address is faulted
   always @(posedge gclk) begin
      ibus_rsp_i <= '0;
      if (grst || !ibus_req_o.cyc) begin
         slave_busy = 1'b0;
      end else if (!ibus_rsp_i.ack) begin
         if (!slave_busy) begin
            slave_busy = 1'b1;
            slave_wait = $urandom_range(5, 0);
         end
         if (fault_on && ibus_req_o.adr == FAULT_PC) begin
            slave_busy = 1'b1;         // Never answer
         end else if (slave_wait == 0) begin
            ibus_rsp_i <= '{ack: 1'b1, dat: word_hash(ibus_req_o.adr)};
         end else begin
            slave_wait--;
         end
      end
   end

   task automatic check_delivery();
      pc_t want;
      want = exp_pc;
      if (br_pend) begin
         if (fet_o.pc == exp_pc) begin
            exp_pc = br_tgt;           // Word already hit as the branch was taken
         end else begin
            want   = br_tgt;
            exp_pc = br_tgt + pc_t'(1);
         end
         br_pend = 1'b0;
      end else begin
         exp_pc = exp_pc + pc_t'(1);
      end
      check_value("fet_o.pc", 64'(fet_o.pc), 64'(want));
      check_value("fet_o.instr", 64'(fet_o.instr), 64'(word_hash(want)));
      check_value("pc_ex_o", 64'(pc_ex_o), 64'(h2));
      check_value("pc_mx_o", 64'(pc_mx_o), 64'(h3));
      h3          = h2;
      h2          = h1;
      h1          = fet_o.pc;
      last_del_pc = fet_o.pc;
      del_count++;
   endtask

   // Reference model samples mid cycle where everything is settled
   always @(negedge gclk) begin
      if (grst) begin
         exp_pc  = RESET_PC;
         br_pend = 1'b0;
         h1      = '0;
         h2      = '0;
         h3      = '0;
      end else begin
         if (fet_o.valid) check_delivery();
         if (ibus_req_o.cyc && !prev_cyc && ibus_req_o.adr >= win_lo &&
             ibus_req_o.adr < win_lo + pc_t'(10)) begin
            win_reads++;
         end
         prev_cyc = ibus_req_o.cyc;
         if (exc_iwb_o) begin
            exc_count++;
            check_value("ibus_req_o.cyc", 64'(ibus_req_o.cyc), 64'(0));
            br_pend = 1'b0;            // Fault flushes a parked branch
            exp_pc  = EXC_VECTOR_PC;
         end else if (bra_i.valid) begin
            br_pend = 1'b1;
            br_tgt  = bra_i.target;
         end else if (hzd_i && fet_o.valid && !br_pend) begin
            exp_pc = fet_o.pc;         // Replay
            replay_count++;
         end
      end
   end

   task automatic send_branch(input pc_t tgt);
      while (br_pend) @(posedge gclk);
      @(negedge gclk);
      force_tgt = tgt;
      br_seq++;
      @(negedge gclk);
   endtask

   task automatic wait_for_pc(input pc_t pc, input int budget);
      int start;
      start = del_count;
      repeat (budget) begin
         @(posedge gclk);
         if (del_count > start && last_del_pc == pc) return;
      end
      errors++;
      $display("Timeout waiting for delivery of PC 0x%0h", pc);
   endtask

   task automatic report_test(input string name, input int err0);
      $display("Test %s finished with %0d errors", name, errors - err0);
   endtask

   initial begin
      int err0;
      int n0;
      void'($urandom(24));
      repeat (5) @(posedge gclk);
      grst <= 1'b0;

      err0 = errors;
      wait_for_pc(pc_t'(19), 200);
      report_test("1 sequential fetch", err0);

      err0 = errors;
      repeat (50) if (!ibus_req_o.cyc) @(negedge gclk);
      send_branch(pc_t'(40));          // Lands while a refill runs
      wait_for_pc(pc_t'(40), 200);
      send_branch(pc_t'(5));
      wait_for_pc(pc_t'(5), 200);
      report_test("2 branch redirect", err0);

      err0 = errors;
      n0   = replay_count;
      rand_hzd <= 1'b1;
      repeat (300) if (replay_count < n0 + 3) @(posedge gclk);
      rand_hzd <= 1'b0;
      if (replay_count < n0 + 3) begin
         errors++;
         $display("Hazard replay was never taken");
      end
      report_test("3 hazard replay", err0);

      err0 = errors;
      n0   = win_reads;
      send_branch(win_lo);
      wait_for_pc(win_lo + pc_t'(9), 300);
      check_value("loop reads first pass", 64'(win_reads - n0), 64'(10));
      n0 = win_reads;
      send_branch(win_lo);
      wait_for_pc(win_lo + pc_t'(9), 300);
      check_value("loop reads second pass", 64'(win_reads - n0), 64'(0));
      report_test("4 cached loop", err0);

      err0     = errors;
      n0       = exc_count;
      fault_on <= 1'b1;
      send_branch(FAULT_PC);
      repeat (100) if (exc_count == n0) @(posedge gclk);
      check_value("exc_iwb_o pulses", 64'(exc_count - n0), 64'(1));
      wait_for_pc(EXC_VECTOR_PC, 100);
      repeat (20) @(posedge gclk);
      check_value("exc_iwb_o pulses after", 64'(exc_count - n0), 64'(1));
      fault_on <= 1'b0;
      report_test("5 bus timeout", err0);

      err0 = errors;
      n0   = del_count;
      rand_adv <= 1'b1;
      rand_br  <= 1'b1;
      rand_hzd <= 1'b1;
      repeat (RANDOM_CYCLES) @(posedge gclk);
      rand_br  <= 1'b0;
      rand_hzd <= 1'b0;
      if (del_count == n0) begin
         errors++;
         $display("No instruction delivered during the random run");
      end
      report_test("6 random mix", err0);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire
